//--- tb.f
+incdir+dv
hw/sd_proto_pkg.sv
hw/sd_ctrl_pkg.sv
hw/sd_sck_gen.sv
hw/sd_cmd_sender.sv
hw/sd_receiver.sv
hw/sd_controller.sv
hw/sd_top.sv
dv/sd_card_model.sv
dv/tb_sd_top.sv

//--- dv/sd_pattern.svh
// Byte idx of block blk in the test data set
function automatic logic [7:0] pattern_byte(input logic [31:0] blk, input int unsigned idx);
  logic [31:0] sum;
  sum = blk * 32'd7 + idx * 32'd13 + 32'h5A;
  return sum[7:0];  // Low 8 bits only
endfunction

//--- dv/tb_sd_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sd_top;

  import sd_proto_pkg::*;
  import sd_ctrl_pkg::*;

  localparam int SLOW_DIV     = 8;
  localparam int FAST_DIV     = 2;
  localparam int RESP_TIMEOUT = 8192;
  localparam int VALID_BLOCKS = 1024;
  localparam int WAIT_LIMIT   = 100000;  // Clocks allowed for any single wait
  localparam int RANDOM_READS = 20;

  logic      clock;
  logic      reset;
  logic      rd_en;
  blk_addr_t addr;
  logic      miso;
  logic      cs;
  logic      sck;
  logic      mosi;
  logic      busy;
  logic      read_valid;
  logic      read_error;
  block_t    read_data;

  integer    seed;
  blk_addr_t expect_q[$];  // Reads waiting for their result
  blk_addr_t rand_addr;
  int        half_cnt;
  logic      sck_prev;
  bit        half_seen;
  bit        busy_fell;

  `include "sd_pattern.svh"

  sd_top #(
    .SLOW_DIV     (SLOW_DIV),
    .FAST_DIV     (FAST_DIV),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) UUT (
    .clock      (clock),
    .reset      (reset),
    .rd_en      (rd_en),
    .addr       (addr),
    .miso       (miso),
    .cs         (cs),
    .sck        (sck),
    .mosi       (mosi),
    .busy       (busy),
    .read_valid (read_valid),
    .read_error (read_error),
    .read_data  (read_data)
  );

  sd_card_model #(
    .NUM_BLOCKS (VALID_BLOCKS)
  ) card (
    .cs   (cs),
    .sck  (sck),
    .mosi (mosi),
    .miso (miso)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    assert (got === exp) else
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
  endtask

  // Expected block, first byte in the top 8 bits
  function automatic block_t ref_block(input blk_addr_t blk);
    block_t data;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      data[$bits(block_t) - 1 - 8 * i -: 8] = pattern_byte(blk, i);
    end
    return data;
  endfunction

  task automatic wait_busy(input logic level, input string what);
    int n;
    n = 0;
    do begin
      @(posedge clock);
      n++;
      assert (n <= WAIT_LIMIT) else fail_run({"Timed out waiting for ", what});
    end while (busy !== level);
  endtask

  task automatic issue_read(input blk_addr_t blk);
    wait_busy(1'b0, "busy low before a read");
    rd_en <= 1'b1;
    addr  <= blk;
    expect_q.push_back(blk);
    @(posedge clock);
    rd_en <= 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  // sck half period in clocks, seen at the port
  always @(posedge clock) begin
    if (reset) begin
      half_cnt  = 0;
      half_seen = 1'b0;
      busy_fell = 1'b0;
      sck_prev  = 1'b0;
    end else begin
      half_cnt = half_cnt + 1;
      if (sck !== sck_prev) begin
        if (half_seen && !busy_fell) begin
          assert (half_cnt == SLOW_DIV) else fail_run($sformatf(
            "ERROR sck half period during init: got %h, expected %h", half_cnt, SLOW_DIV));
        end else if (half_seen && !cs) begin
          assert (half_cnt == FAST_DIV) else fail_run($sformatf(
            "ERROR sck half period during a read: got %h, expected %h", half_cnt, FAST_DIV));
        end
        half_seen = 1'b1;
        half_cnt  = 0;
      end
      if (!busy) busy_fell = 1'b1;
      sck_prev = sck;
    end
  end

  always @(posedge clock) begin
    assert (!card.cmd_error) else
      fail_run({"Card model reported an error: ", card.error_msg});
  end

  always @(posedge clock) begin : compare_results
    blk_addr_t blk;
    block_t    expected;
    if (!reset && (read_valid || read_error)) begin
      assert (expect_q.size() > 0) else fail_run("A read result arrived with no read outstanding");
      blk = expect_q.pop_front();
      if (blk < VALID_BLOCKS) begin
        expect_level($sformatf("read_valid for block %0d", blk), read_valid, 1'b1);
        expect_level($sformatf("read_error for block %0d", blk), read_error, 1'b0);
        expected = ref_block(blk);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          assert (read_data[4095 - 8 * i -: 8] === expected[4095 - 8 * i -: 8]) else
            fail_run($sformatf("ERROR read_data byte %0d of block %0d: got %h, expected %h",
                               i, blk, read_data[4095 - 8 * i -: 8],
                               expected[4095 - 8 * i -: 8]));
        end
      end else begin
        expect_level($sformatf("read_error for block %0d", blk), read_error, 1'b1);
        expect_level($sformatf("read_valid for block %0d", blk), read_valid, 1'b0);
      end
    end
  end

  initial begin
    seed  = 32'h6c43;
    reset = 1'b1;
    rd_en = 1'b0;
    addr  = '0;
    repeat (3) @(posedge clock);
    expect_level("cs after reset", cs, 1'b1);
    expect_level("busy after reset", busy, 1'b1);
    expect_level("read_valid after reset", read_valid, 1'b0);
    expect_level("read_error after reset", read_error, 1'b0);
    expect_level("mosi after reset", mosi, 1'b1);
    reset <= 1'b0;

    wait_busy(1'b0, "initialization to finish");
    assert (card.init_clocks >= 80) else fail_run($sformatf(
      "Only %0d sck rising edges with cs high came before the first command", card.init_clocks));
    repeat (32) @(posedge clock);  // Fast rate takes over at the next sck fall

    issue_read(32'd0);
    issue_read(32'd1023);
    issue_read(32'd2000);  // Out of range
    issue_read(32'd5);     // Bad CRC on the first transfer
    wait_busy(1'b0, "the block 5 read to finish");
    assert (card.block5_reads == 2) else fail_run($sformatf(
      "Block 5 was read %0d times instead of once plus one retry", card.block5_reads));

    repeat (RANDOM_READS) begin
      rand_addr = $unsigned($random(seed)) % VALID_BLOCKS;
      issue_read(rand_addr);
    end
    wait_busy(1'b0, "the last read to finish");
    @(posedge clock);

    if (expect_q.size() == 0 && !card.cmd_error) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("The run ended with reads still outstanding or a card model error");
    end
  end

endmodule

`default_nettype wire

//--- dv/sd_card_model.sv
`timescale 1ns/100ps
`default_nettype none

module sd_card_model #(
  parameter int NUM_BLOCKS = 1024
) (
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  import sd_proto_pkg::*;

  logic [47:0] cmd_shift;
  int          cmd_bits;
  bit          receiving;
  bit          seen_start;
  bit          idle_done;     // CMD0 accepted
  bit          if_cond_done;  // CMD8 accepted
  bit          app_pending;   // Previous command was CMD55
  bit          ready;         // Card has left the idle state
  int          acmd41_count;
  int          init_clocks;   // sck rises with cs high before the first command
  int          block5_reads;
  bit          cmd_error;
  string       error_msg;
  bit          tx_q[$];       // Bits waiting to go out on miso

  `include "sd_pattern.svh"

  // Long division of the head by x^7 + x^3 + 1
  function automatic logic [6:0] cmd_crc7(input logic [39:0] head);
    logic [46:0] rem;
    rem = {head, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int j = 7; j >= 0; j--) begin
      c = (c[15] ^ data[j]) ? ((c << 1) ^ 16'h1021) : (c << 1);
    end
    return c;
  endfunction

  task automatic flag_error(input string msg);
    if (!cmd_error) begin  // Keep the first message
      cmd_error = 1'b1;
      error_msg = msg;
    end
  endtask

  task automatic queue_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      tx_q.push_back(b[i]);
    end
  endtask

  task automatic queue_block(input logic [31:0] blk);
    logic [15:0] crc;
    logic [7:0]  b;
    crc = '0;
    queue_byte(8'hFF);  // Access delay before the token
    queue_byte(START_TOKEN);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      b = pattern_byte(blk, i);
      crc = crc16_byte(crc, b);
      queue_byte(b);
    end
    if (blk == 32'd5 && block5_reads == 1) begin
      crc = crc ^ 16'h8001;  // First read of block 5 goes out damaged
    end
    queue_byte(crc[15:8]);
    queue_byte(crc[7:0]);
  endtask

  task automatic handle_command(input logic [47:0] frame);
    cmd_index_t idx;
    cmd_arg_t   arg;
    bit         was_app;
    idx = frame[45:40];
    arg = frame[39:8];
    was_app = app_pending;
    app_pending = 1'b0;
    if (frame[47:46] != 2'b01 || frame[0] != 1'b1) begin
      flag_error($sformatf("Command %0d has bad start, transmission or stop bits", idx));
    end
    if (frame[7:1] != cmd_crc7(frame[47:8])) begin
      flag_error($sformatf("Command %0d carries a wrong CRC7", idx));
    end
    if (was_app && idx != ACMD41) begin
      flag_error($sformatf("CMD55 was followed by command %0d", idx));
    end
    queue_byte(8'hFF);  // One byte of response delay
    case (idx)
      CMD0: begin
        idle_done    = 1'b1;
        if_cond_done = 1'b0;
        ready        = 1'b0;
        acmd41_count = 0;
        queue_byte(R1_IDLE);
      end
      CMD8: begin
        if (!idle_done) flag_error("CMD8 arrived before CMD0");
        if_cond_done = 1'b1;
        queue_byte(R1_IDLE);
        queue_byte(8'h00);
        queue_byte(8'h00);
        queue_byte({4'h0, arg[11:8]});  // Voltage accepted
        queue_byte(arg[7:0]);           // Check pattern echo
      end
      CMD55: begin
        if (!if_cond_done) flag_error("CMD55 arrived before CMD8");
        app_pending = 1'b1;
        queue_byte(ready ? R1_READY : R1_IDLE);
      end
      ACMD41: begin
        if (!was_app) flag_error("ACMD41 arrived without CMD55");
        if (!arg[30]) flag_error("ACMD41 arrived without the HCS bit");
        acmd41_count++;
        if (acmd41_count > 2) ready = 1'b1;  // Idle twice, then ready
        queue_byte(ready ? R1_READY : R1_IDLE);
      end
      CMD17: begin
        if (!ready) flag_error("CMD17 arrived before initialization finished");
        if (arg < NUM_BLOCKS) begin
          if (arg == 32'd5) block5_reads++;
          queue_byte(R1_READY);
          queue_block(arg);
        end else begin
          queue_byte(8'h40);  // Parameter error
          queue_byte(8'hFF);
          queue_byte(8'h08);  // Out of range token
        end
      end
      default: begin
        flag_error($sformatf("Unexpected command %0d", idx));
        queue_byte(8'h04);  // Illegal command
      end
    endcase
  endtask

  initial begin
    miso = 1'b1;
  end

  always @(posedge sck) begin
    if (cs) begin
      receiving = 1'b0;
      if (!seen_start) init_clocks++;
    end else if (receiving) begin
      cmd_shift = {cmd_shift[46:0], mosi};
      cmd_bits++;
      if (cmd_bits == 48) begin
        receiving = 1'b0;
        handle_command(cmd_shift);
      end
    end else if (mosi == 1'b0) begin  // Start bit of a command
      seen_start = 1'b1;
      receiving  = 1'b1;
      cmd_shift  = '0;
      cmd_bits   = 1;
    end
  end

  always @(negedge sck) begin
    if (tx_q.size() > 0) begin
      miso <= tx_q.pop_front();
    end else begin
      miso <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/sd_top.sv
`timescale 1ns/100ps
`default_nettype none

module sd_top #(
  parameter int SLOW_DIV     = 8,
  parameter int FAST_DIV     = 2,
  parameter int RESP_TIMEOUT = 8192
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   rd_en,
  input  sd_ctrl_pkg::blk_addr_t addr,
  input  logic                   miso,
  output logic                   cs,
  output logic                   sck,
  output logic                   mosi,
  output logic                   busy,
  output logic                   read_valid,
  output logic                   read_error,
  output sd_ctrl_pkg::block_t    read_data
);

  import sd_proto_pkg::*;
  import sd_ctrl_pkg::*;

  logic       fast;
  logic       shift_en;
  logic       sample_en;
  logic       cmd_valid;
  cmd_index_t cmd_index;
  cmd_arg_t   argument;
  logic       sending;
  logic       resp_start;
  resp_kind_t resp_kind;
  logic       resp_done;
  logic       resp_timeout;
  logic       block_ok;
  resp_t      resp_data;
  block_t     block_data;

  sd_sck_gen #(
    .SLOW_DIV (SLOW_DIV),
    .FAST_DIV (FAST_DIV)
  ) u_sck_gen (
    .clock     (clock),
    .reset     (reset),
    .fast      (fast),
    .sck       (sck),
    .shift_en  (shift_en),
    .sample_en (sample_en)
  );

  sd_cmd_sender u_cmd_sender (
    .clock     (clock),
    .reset     (reset),
    .shift_en  (shift_en),
    .cmd_valid (cmd_valid),
    .cmd_index (cmd_index),
    .argument  (argument),
    .mosi      (mosi),
    .sending   (sending)
  );

  sd_receiver #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_receiver (
    .clock        (clock),
    .reset        (reset),
    .sample_en    (sample_en),
    .miso         (miso),
    .sending      (sending),
    .resp_start   (resp_start),
    .resp_kind    (resp_kind),
    .resp_done    (resp_done),
    .resp_timeout (resp_timeout),
    .block_ok     (block_ok),
    .resp_data    (resp_data),
    .block_data   (block_data)
  );

  sd_controller u_controller (
    .clock        (clock),
    .reset        (reset),
    .rd_en        (rd_en),
    .addr         (addr),
    .shift_en     (shift_en),
    .sending      (sending),
    .resp_done    (resp_done),
    .resp_timeout (resp_timeout),
    .block_ok     (block_ok),
    .resp_data    (resp_data),
    .block_data   (block_data),
    .cmd_valid    (cmd_valid),
    .cmd_index    (cmd_index),
    .argument     (argument),
    .resp_start   (resp_start),
    .resp_kind    (resp_kind),
    .cs           (cs),
    .fast         (fast),
    .busy         (busy),
    .read_valid   (read_valid),
    .read_error   (read_error),
    .read_data    (read_data)
  );

endmodule

`default_nettype wire

//--- hw/sd_controller.sv
`timescale 1ns/100ps
`default_nettype none

module sd_controller (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     rd_en,
  input  sd_ctrl_pkg::blk_addr_t   addr,
  input  logic                     shift_en,
  input  logic                     sending,
  input  logic                     resp_done,
  input  logic                     resp_timeout,
  input  logic                     block_ok,
  input  sd_ctrl_pkg::resp_t       resp_data,
  input  sd_ctrl_pkg::block_t      block_data,
  output logic                     cmd_valid,
  output sd_proto_pkg::cmd_index_t cmd_index,
  output sd_proto_pkg::cmd_arg_t   argument,
  output logic                     resp_start,
  output sd_proto_pkg::resp_kind_t resp_kind,
  output logic                     cs,
  output logic                     fast,
  output logic                     busy,
  output logic                     read_valid,
  output logic                     read_error,
  output sd_ctrl_pkg::block_t      read_data
);

  import sd_proto_pkg::*;
  import sd_ctrl_pkg::*;

  localparam int INIT_CLOCKS = 80;

  ctrl_state_t state;
  ctrl_state_t ret_state;  // Check state to enter after the response
  logic [6:0]  clk_cnt;
  r1_t         r1;         // R1 of a short response
  r1_t         r1_r7;      // R1 at the head of R7
  logic        block_good;

  assign r1         = resp_data[7:0];
  assign r1_r7      = resp_data[39:32];
  assign block_good = block_ok && !resp_timeout;

  task automatic send_cmd(input cmd_index_t idx, input cmd_arg_t arg, input resp_kind_t kind,
                          input ctrl_state_t ret);
    cmd_index <= idx;
    argument  <= arg;
    resp_kind <= kind;
    ret_state <= ret;
    state     <= CS_SEND;
  endtask

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= CS_INIT_CLOCKS;
      ret_state  <= CS_CHECK_CMD0;
      clk_cnt    <= '0;
      cmd_valid  <= 1'b0;
      cmd_index  <= CMD0;
      argument   <= '0;
      resp_start <= 1'b0;
      resp_kind  <= RESP_R1;
      cs         <= 1'b1;
      fast       <= 1'b0;
      busy       <= 1'b1;
      read_valid <= 1'b0;
      read_error <= 1'b0;
    end else begin
      cmd_valid  <= 1'b0;
      resp_start <= 1'b0;
      read_valid <= 1'b0;
      read_error <= 1'b0;
      case (state)
        CS_INIT_CLOCKS: begin  // Dummy clocks with cs high
          cs <= 1'b1;
          if (shift_en) begin
            if (clk_cnt == 7'(INIT_CLOCKS - 1)) begin
              clk_cnt <= '0;
              send_cmd(CMD0, '0, RESP_R1, CS_CHECK_CMD0);
            end else begin
              clk_cnt <= clk_cnt + 1'b1;
            end
          end
        end
        CS_SEND: begin  // Sender and receiver start together
          cs         <= 1'b0;
          cmd_valid  <= 1'b1;
          resp_start <= 1'b1;
          state      <= CS_WAIT_SEND;
        end
        CS_WAIT_SEND: if (sending) state <= CS_WAIT_RESP;
        CS_WAIT_RESP: if (resp_done) state <= ret_state;
        CS_CHECK_CMD0: begin
          if (!resp_timeout && r1 == R1_IDLE) begin
            send_cmd(CMD8, CMD8_ARG, RESP_R7, CS_CHECK_CMD8);
          end else begin
            send_cmd(CMD0, '0, RESP_R1, CS_CHECK_CMD0);
          end
        end
        CS_CHECK_CMD8: begin
          if (resp_timeout || r1_r7 != R1_IDLE) begin
            send_cmd(CMD0, '0, RESP_R1, CS_CHECK_CMD0);
          end else if (resp_data[7:0] != CMD8_ARG[7:0]) begin
            send_cmd(CMD8, CMD8_ARG, RESP_R7, CS_CHECK_CMD8);  // Bad echo
          end else if (resp_data[11:8] != CMD8_ARG[11:8]) begin
            cs    <= 1'b1;  // Voltage refused, start over
            state <= CS_INIT_CLOCKS;
          end else begin
            send_cmd(CMD55, '0, RESP_R1, CS_CHECK_CMD55);
          end
        end
        CS_CHECK_CMD55: begin
          if (resp_timeout) begin
            send_cmd(CMD0, '0, RESP_R1, CS_CHECK_CMD0);
          end else if ((r1 & ~R1_IDLE) == R1_READY) begin
            send_cmd(ACMD41, ACMD41_ARG, RESP_R1, CS_CHECK_ACMD41);
          end else begin
            send_cmd(CMD55, '0, RESP_R1, CS_CHECK_CMD55);
          end
        end
        CS_CHECK_ACMD41: begin
          if (resp_timeout) begin
            send_cmd(CMD0, '0, RESP_R1, CS_CHECK_CMD0);
          end else if (r1 == R1_READY) begin
            fast  <= 1'b1;  // Card left idle
            state <= CS_IDLE;
          end else begin
            send_cmd(CMD55, '0, RESP_R1, CS_CHECK_CMD55);
          end
        end
        CS_IDLE: begin
          cs <= 1'b1;
          if (busy) begin
            busy <= 1'b0;  // One cycle after the result pulse
          end else if (rd_en) begin
            busy <= 1'b1;
            send_cmd(CMD17, addr, RESP_R1, CS_CHECK_CMD17);
          end
        end
        CS_CHECK_CMD17: begin
          if (resp_timeout) begin
            send_cmd(CMD17, argument, RESP_R1, CS_CHECK_CMD17);
          end else begin
            resp_start <= 1'b1;
            state      <= CS_WAIT_RESP;
            if (r1 == R1_READY) begin
              resp_kind <= RESP_DATA;
              ret_state <= CS_CHECK_READ;
            end else begin
              resp_kind <= RESP_TOKEN;  // Card answers with an error token
              ret_state <= CS_CHECK_TOKEN;
            end
          end
        end
        CS_CHECK_READ: begin
          if (block_good) begin
            read_valid <= 1'b1;
            state      <= CS_IDLE;
          end else begin
            send_cmd(CMD17, argument, RESP_R1, CS_CHECK_CMD17);  // Retry
          end
        end
        CS_CHECK_TOKEN: begin
          if (!resp_timeout && r1[TOKEN_OUT_OF_RANGE]) begin
            read_error <= 1'b1;
            state      <= CS_IDLE;
          end else begin
            send_cmd(CMD17, argument, RESP_R1, CS_CHECK_CMD17);
          end
        end
        default: state <= CS_INIT_CLOCKS;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == CS_CHECK_READ && block_good) begin
      read_data <= block_data;
    end
  end

  // Each read result hands control back to the client on the next cycle
  a_busy_after_result: assert property (@(posedge clock) disable iff (reset)
    (read_valid || read_error) |=> !busy);

endmodule

`default_nettype wire

//--- hw/sd_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module sd_receiver #(
  parameter int RESP_TIMEOUT = 8192
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     sample_en,
  input  logic                     miso,
  input  logic                     sending,
  input  logic                     resp_start,
  input  sd_proto_pkg::resp_kind_t resp_kind,
  output logic                     resp_done,
  output logic                     resp_timeout,
  output logic                     block_ok,
  output sd_ctrl_pkg::resp_t       resp_data,
  output sd_ctrl_pkg::block_t      block_data
);

  import sd_proto_pkg::*;
  import sd_ctrl_pkg::*;

  localparam int DATA_BITS = BLOCK_BYTES * 8;
  localparam int BW = $clog2(DATA_BITS + 16);
  localparam int TW = $clog2(RESP_TIMEOUT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HUNT,
    RX_SHIFT
  } rx_state_t;

  rx_state_t     state;
  resp_kind_t    kind;
  logic [BW-1:0] bit_cnt;
  logic [BW-1:0] last_bit;
  logic [TW-1:0] wait_cnt;
  logic [7:0]    hunt_win;
  logic [7:0]    win_next;
  logic [15:0]   crc_calc;
  logic [15:0]   crc_next;
  logic [15:0]   crc_rx;
  logic          hunting;
  logic          got_start;
  logic          take_bit;
  logic          in_data;

  assign hunting   = sample_en && (state == RX_HUNT) && !sending;
  assign take_bit  = sample_en && (state == RX_SHIFT);
  assign win_next  = {hunt_win[6:0], miso};
  // Data waits for the token byte, the rest start on the first 0
  assign got_start = (kind == RESP_DATA) ? (win_next == START_TOKEN) : !miso;
  assign in_data   = bit_cnt < BW'(DATA_BITS);
  // CRC16-CCITT, poly 0x1021, zero seed
  assign crc_next  = {crc_calc[14:0], 1'b0} ^ ((crc_calc[15] ^ miso) ? 16'h1021 : 16'h0000);

  always_comb begin
    case (kind)
      RESP_R7:   last_bit = BW'(39);
      RESP_DATA: last_bit = BW'(DATA_BITS + 15);
      default:   last_bit = BW'(7);  // R1 and error token
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state        <= RX_IDLE;
      kind         <= RESP_R1;
      bit_cnt      <= '0;
      wait_cnt     <= '0;
      hunt_win     <= 8'hFF;
      crc_calc     <= '0;
      resp_done    <= 1'b0;
      resp_timeout <= 1'b0;
      block_ok     <= 1'b0;
    end else begin
      resp_done <= 1'b0;
      if (resp_start) begin
        state        <= RX_HUNT;
        kind         <= resp_kind;
        wait_cnt     <= '0;
        hunt_win     <= 8'hFF;
        crc_calc     <= '0;
        resp_timeout <= 1'b0;
        block_ok     <= 1'b0;
      end else if (hunting) begin
        hunt_win <= win_next;
        if (got_start) begin
          state   <= RX_SHIFT;
          bit_cnt <= (kind == RESP_DATA) ? '0 : BW'(1);  // Start bit is R1 bit 7
        end else if (wait_cnt == TW'(RESP_TIMEOUT - 1)) begin
          state        <= RX_IDLE;
          resp_done    <= 1'b1;
          resp_timeout <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end else if (take_bit) begin
        if (kind == RESP_DATA && in_data) begin
          crc_calc <= crc_next;
        end
        if (bit_cnt == last_bit) begin
          state     <= RX_IDLE;
          resp_done <= 1'b1;
          block_ok  <= (kind == RESP_DATA) && ({crc_rx[14:0], miso} == crc_calc);
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resp_start) begin
      resp_data <= '0;
    end else if (kind != RESP_DATA && (take_bit || (hunting && got_start))) begin
      resp_data <= {resp_data[38:0], miso};
    end else if (kind == RESP_DATA && take_bit) begin
      if (in_data) begin
        block_data <= {block_data[DATA_BITS-2:0], miso};
      end else begin
        crc_rx <= {crc_rx[14:0], miso};
      end
    end
  end

  // The controller starts one reception at a time
  a_start_when_idle: assert property (@(posedge clock) disable iff (reset)
    resp_start |-> state == RX_IDLE);

endmodule

`default_nettype wire

//--- hw/sd_cmd_sender.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_sender (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     shift_en,
  input  logic                     cmd_valid,
  input  sd_proto_pkg::cmd_index_t cmd_index,
  input  sd_proto_pkg::cmd_arg_t   argument,
  output logic                     mosi,
  output logic                     sending
);

  logic [39:0] head;       // Start, transmission, index, argument
  logic [47:0] frame;
  logic [47:0] shift_reg;
  logic [5:0]  bit_cnt;

  // CRC7 with x^7 + x^3 + 1, one bit at a time, MSB first
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] crc;
    logic       feedback;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      feedback = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0};
      if (feedback) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  assign head  = {2'b01, cmd_index, argument};
  assign frame = {head, crc7(head), 1'b1};  // Stop bit closes the frame

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sending <= 1'b0;
      bit_cnt <= '0;
      mosi    <= 1'b1;
    end else if (cmd_valid) begin
      sending <= 1'b1;
      bit_cnt <= '0;
    end else if (sending && shift_en) begin
      mosi <= shift_reg[47];
      if (bit_cnt == 6'd47) begin
        sending <= 1'b0;  // Stop bit stays on mosi as the idle level
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_valid) begin
      shift_reg <= frame;
    end else if (sending && shift_en) begin
      shift_reg <= {shift_reg[46:0], 1'b1};
    end
  end

  // The controller must wait for the previous frame to leave
  a_no_overlap: assert property (@(posedge clock) disable iff (reset)
    cmd_valid |-> !sending);

endmodule

`default_nettype wire

//--- hw/sd_sck_gen.sv
`timescale 1ns/100ps
`default_nettype none

module sd_sck_gen #(
  parameter int SLOW_DIV = 8,
  parameter int FAST_DIV = 2
) (
  input  logic clock,
  input  logic reset,
  input  logic fast,
  output logic sck,
  output logic shift_en,
  output logic sample_en
);

  localparam int MAX_DIV = (SLOW_DIV > FAST_DIV) ? SLOW_DIV : FAST_DIV;
  localparam int CW = $clog2(MAX_DIV + 1);

  logic [CW-1:0] half_cnt;
  logic [CW-1:0] slow_load;
  logic [CW-1:0] fast_load;
  logic          rate_fast;  // Rate in use for the current period

  assign slow_load = CW'(SLOW_DIV - 1);
  assign fast_load = CW'(FAST_DIV - 1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sck       <= 1'b0;  // Mode 0 idles low
      half_cnt  <= CW'(SLOW_DIV - 1);
      rate_fast <= 1'b0;
      shift_en  <= 1'b0;
      sample_en <= 1'b0;
    end else begin
      shift_en  <= 1'b0;
      sample_en <= 1'b0;
      if (half_cnt != '0) begin
        half_cnt <= half_cnt - 1'b1;
      end else begin
        sck <= !sck;
        if (sck) begin
          // Falling edge, the only point where the rate may change
          shift_en  <= 1'b1;
          rate_fast <= fast;
          half_cnt  <= fast ? fast_load : slow_load;
        end else begin
          sample_en <= 1'b1;  // Rising edge
          half_cnt  <= rate_fast ? fast_load : slow_load;
        end
      end
    end
  end

  // The fast rate holds until reset
  a_fast_holds: assert property (@(posedge clock) disable iff (reset)
    !$fell(fast));

endmodule

`default_nettype wire

//--- hw/sd_ctrl_pkg.sv
`default_nettype none

package sd_ctrl_pkg;

  // First received byte sits in the top 8 bits
  typedef logic [sd_proto_pkg::BLOCK_BYTES*8-1:0] block_t;

  // R7 keeps R1 in [39:32], a plain R1 lands in [7:0]
  typedef logic [39:0] resp_t;

  typedef logic [31:0] blk_addr_t;

  typedef enum logic [3:0] {
    CS_INIT_CLOCKS,
    CS_SEND,
    CS_WAIT_SEND,
    CS_WAIT_RESP,
    CS_CHECK_CMD0,
    CS_CHECK_CMD8,
    CS_CHECK_CMD55,
    CS_CHECK_ACMD41,
    CS_IDLE,
    CS_CHECK_CMD17,
    CS_CHECK_READ,
    CS_CHECK_TOKEN
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

  // Command indices
  typedef logic [5:0] cmd_index_t;

  localparam cmd_index_t CMD0   = 6'd0;   // GO_IDLE_STATE
  localparam cmd_index_t CMD8   = 6'd8;   // SEND_IF_COND
  localparam cmd_index_t CMD17  = 6'd17;  // READ_SINGLE_BLOCK
  localparam cmd_index_t CMD55  = 6'd55;  // APP_CMD prefix
  localparam cmd_index_t ACMD41 = 6'd41;  // SD_SEND_OP_COND

  // Command arguments
  typedef logic [31:0] cmd_arg_t;

  localparam cmd_arg_t CMD8_ARG   = 32'h0000_01AA;  // Voltage 0x1, check pattern 0xAA
  localparam cmd_arg_t ACMD41_ARG = 32'h4000_0000;  // HCS set

  // R1 response byte
  typedef logic [7:0] r1_t;

  localparam r1_t R1_IDLE  = 8'h01;
  localparam r1_t R1_READY = 8'h00;

  // Data and error tokens
  localparam logic [7:0] START_TOKEN = 8'hFE;
  localparam int TOKEN_OUT_OF_RANGE = 3;  // Bit index in the error token

  // Response shape the receiver is asked to collect
  typedef enum logic [1:0] {
    RESP_R1,
    RESP_R7,
    RESP_DATA,
    RESP_TOKEN
  } resp_kind_t;

  localparam int BLOCK_BYTES = 512;

endpackage

`default_nettype wire
